// File: Makefile
# Verilator build and run of the cache testbench

VERILATOR  ?= verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_cache_top
FILELIST   = src.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/cache_arrays.sv
`timescale 1ns/10ps
`default_nettype none

module cache_arrays (
  input  logic                             clk,
  input  logic                             reset,
  input  cache_pkg::cache_addr_t           addr,
  input  logic [cache_pkg::data_w-1:0]     wdata,
  input  logic [cache_pkg::data_w-1:0]     fill_data,
  input  logic [cache_pkg::word_sel_w-1:0] ret_word,
  input  logic                             write_data_array,
  input  logic                             write_tag_array,
  input  logic                             store_hit,
  output logic                             hit,
  output logic [cache_pkg::data_w-1:0]     read_word
);

  // Metadata per set
  logic [cache_pkg::tag_w-1:0]    tags [cache_pkg::num_sets];
  logic [cache_pkg::num_sets-1:0] valid;

  // All blocks flattened, set index above word select
  logic [cache_pkg::data_w-1:0] data_mem [cache_pkg::num_sets * cache_pkg::block_words];

  logic [cache_pkg::index_w-1:0]    index;
  logic [cache_pkg::word_sel_w-1:0] word_sel;

  assign index = addr.f.index;
  // Byte bit 0 is dropped
  assign word_sel = addr.f.offset[cache_pkg::offset_w-1:1];

  // Valid bits are the only state cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (write_tag_array) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_tag_array) begin
      tags[index] <= addr.f.tag;
    end
  end

  // Fill and store never overlap, fill wins anyway
  always_ff @(posedge clk) begin
    if (write_data_array) begin
      data_mem[{index, ret_word}] <= fill_data;
    end else if (store_hit) begin
      data_mem[{index, word_sel}] <= wdata;
    end
  end

  // Combinational lookup
  assign hit = valid[index] & (tags[index] == addr.f.tag);
  assign read_word = data_mem[{index, word_sel}];

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Data word and byte address widths
  localparam int data_w = 16;
  localparam int addr_w = 16;

  // Address split into tag, set index and byte offset
  localparam int tag_w = 6;
  localparam int index_w = 6;
  localparam int offset_w = 4;
  // Offset bits above bit 0 select one word in the block
  localparam int word_sel_w = 3;

  // Direct-mapped geometry
  localparam int block_words = 8;
  localparam int num_sets = 64;

  // Multicycle main memory
  localparam int mem_latency = 4;
  localparam int mem_words = 32768;

  // Tag in the upper bits, byte offset at the bottom
  typedef struct packed {
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
  } addr_fields_t;

  // One address word, read flat by memory and split by the cache
  typedef union packed {
    logic [addr_w-1:0] raw;
    addr_fields_t      f;
  } cache_addr_t;

  // Block fill sequencing
  typedef enum logic [1:0] {
    fill_idle    = 2'd0,
    fill_request = 2'd1,
    fill_drain   = 2'd2
  } fill_state_t;

endpackage

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         rd,
  input  logic                         wr,
  input  cache_pkg::cache_addr_t       addr,
  input  logic [cache_pkg::data_w-1:0] wdata,
  output logic [cache_pkg::data_w-1:0] rdata,
  output logic                         stall
);

  mem_bus_if mem_bus ();

  logic                             hit;
  logic                             start;
  logic                             write_data_array;
  logic                             write_tag_array;
  logic                             store_hit;
  logic [cache_pkg::word_sel_w-1:0] req_word;
  logic [cache_pkg::word_sel_w-1:0] ret_word;
  logic                             req_last;
  logic                             ret_last;

  // Miss detection, fill sequencing, write-through
  fill_fsm u_fill_fsm (
    .clk              (clk),
    .reset            (reset),
    .rd               (rd),
    .wr               (wr),
    .addr             (addr),
    .wdata            (wdata),
    .hit              (hit),
    .req_word         (req_word),
    .req_last         (req_last),
    .ret_last         (ret_last),
    .data_valid       (mem_bus.data_valid),
    .start            (start),
    .write_data_array (write_data_array),
    .write_tag_array  (write_tag_array),
    .store_hit        (store_hit),
    .stall            (stall),
    .bus              (mem_bus)
  );

  // Request beats follow the memory enable
  fill_counter u_fill_counter (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .advance    (mem_bus.enable),
    .data_valid (mem_bus.data_valid),
    .req_word   (req_word),
    .req_last   (req_last),
    .ret_word   (ret_word),
    .ret_last   (ret_last)
  );

  // Fill data comes straight off the memory return path
  cache_arrays u_cache_arrays (
    .clk              (clk),
    .reset            (reset),
    .addr             (addr),
    .wdata            (wdata),
    .fill_data        (mem_bus.rdata),
    .ret_word         (ret_word),
    .write_data_array (write_data_array),
    .write_tag_array  (write_tag_array),
    .store_hit        (store_hit),
    .hit              (hit),
    .read_word        (rdata)
  );

  main_memory u_main_memory (
    .clk (clk),
    .bus (mem_bus)
  );

endmodule

`default_nettype wire

// File: hdl/fill_counter.sv
`timescale 1ns/10ps
`default_nettype none

module fill_counter (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  logic                             advance,
  input  logic                             data_valid,
  output logic [cache_pkg::word_sel_w-1:0] req_word,
  output logic                             req_last,
  output logic [cache_pkg::word_sel_w-1:0] ret_word,
  output logic                             ret_last
);

  // Issued requests, one per memory request cycle
  always_ff @(posedge clk) begin
    if (reset || start) begin
      req_word <= '0;
    end else if (advance) begin
      req_word <= req_word + 1'b1;
    end
  end

  // Returned words, trailing the requests by the memory latency
  always_ff @(posedge clk) begin
    if (reset || start) begin
      ret_word <= '0;
    end else if (data_valid) begin
      ret_word <= ret_word + 1'b1;
    end
  end

  // Final beat of the block on each side
  assign req_last = (int'(req_word) == cache_pkg::block_words - 1);
  assign ret_last = (int'(ret_word) == cache_pkg::block_words - 1);

endmodule

`default_nettype wire

// File: hdl/fill_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module fill_fsm (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             rd,
  input  logic                             wr,
  input  cache_pkg::cache_addr_t           addr,
  input  logic [cache_pkg::data_w-1:0]     wdata,
  input  logic                             hit,
  input  logic [cache_pkg::word_sel_w-1:0] req_word,
  input  logic                             req_last,
  input  logic                             ret_last,
  input  logic                             data_valid,
  output logic                             start,
  output logic                             write_data_array,
  output logic                             write_tag_array,
  output logic                             store_hit,
  output logic                             stall,
  mem_bus_if.ctrl                          bus
);

  cache_pkg::fill_state_t state;
  cache_pkg::fill_state_t state_nxt;
  cache_pkg::cache_addr_t fill_addr;
  logic                   access;
  logic                   miss;
  logic                   busy;

  // Requester holds a level while it wants service
  assign access = rd | wr;
  assign miss = access & ~hit;
  assign busy = (state != cache_pkg::fill_idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::fill_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    start = 1'b0;
    write_tag_array = 1'b0;
    case (state)
      cache_pkg::fill_idle: begin
        // Clear the beat counters as the fill begins
        if (miss) begin
          start = 1'b1;
          state_nxt = cache_pkg::fill_request;
        end
      end
      cache_pkg::fill_request: begin
        // One read per cycle, eight in a row
        if (req_last) begin
          state_nxt = cache_pkg::fill_drain;
        end
      end
      cache_pkg::fill_drain: begin
        // Last word lands together with the tag
        if (data_valid && ret_last) begin
          write_tag_array = 1'b1;
          state_nxt = cache_pkg::fill_idle;
        end
      end
      default: begin
        state_nxt = cache_pkg::fill_idle;
      end
    endcase
  end

  // Block base from the request, word from the request counter
  always_comb begin
    fill_addr.f.tag = addr.f.tag;
    fill_addr.f.index = addr.f.index;
    fill_addr.f.offset = {req_word, 1'b0};
  end

  // Write-through only once the block is present
  assign store_hit = ~busy & wr & hit;

  // Returned words go into the data array while a fill runs
  assign write_data_array = busy & data_valid;

  assign bus.enable = (state == cache_pkg::fill_request) | store_hit;
  assign bus.wr = store_hit;
  assign bus.addr = store_hit ? addr : fill_addr;
  assign bus.wdata = wdata;

  // Held until the access can complete from the cache
  assign stall = access & (busy | ~hit);

endmodule

`default_nettype wire

// File: hdl/main_memory.sv
`timescale 1ns/10ps
`default_nettype none

module main_memory (
  input  logic   clk,
  mem_bus_if.mem bus
);

  // Word-addressed backing store, contents start undefined
  logic [cache_pkg::data_w-1:0] mem_array [cache_pkg::mem_words];

  logic [$clog2(cache_pkg::mem_words)-1:0] word_addr;

  // Read address pipeline with one valid bit per stage
  logic [$clog2(cache_pkg::mem_words)-1:0] pipe_addr [cache_pkg::mem_latency];
  logic [cache_pkg::mem_latency-1:0]       pipe_valid;

  // Byte address to word address
  assign word_addr = bus.addr.raw[cache_pkg::addr_w-1:1];

  // Writes land at the edge and never return data
  always_ff @(posedge clk) begin
    if (bus.enable && bus.wr) begin
      mem_array[word_addr] <= bus.wdata;
    end
  end

  // New read accepted every cycle
  always_ff @(posedge clk) begin
    pipe_valid <= {pipe_valid[cache_pkg::mem_latency-2:0], bus.enable & ~bus.wr};
    pipe_addr[0] <= word_addr;
    for (int i = 1; i < cache_pkg::mem_latency; i++) begin
      pipe_addr[i] <= pipe_addr[i-1];
    end
  end

  // Last stage presents the word with a one-cycle strobe
  assign bus.rdata = mem_array[pipe_addr[cache_pkg::mem_latency-1]];
  assign bus.data_valid = pipe_valid[cache_pkg::mem_latency-1];

endmodule

`default_nettype wire

// File: hdl/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

  // Request side
  logic                         enable;
  logic                         wr;
  cache_pkg::cache_addr_t       addr;
  logic [cache_pkg::data_w-1:0] wdata;

  // Return side, valid pulse mem_latency cycles after a read
  logic [cache_pkg::data_w-1:0] rdata;
  logic                         data_valid;

  // Cache control issues reads, fill requests and write-throughs
  modport ctrl (
    output enable,
    output wr,
    output addr,
    output wdata
  );

  // Main memory answers reads and absorbs writes
  modport mem (
    input  enable,
    input  wr,
    input  addr,
    input  wdata,
    output rdata,
    output data_valid
  );

endinterface

`default_nettype wire

// File: src.f
hdl/cache_pkg.sv
hdl/mem_bus_if.sv
hdl/fill_counter.sv
hdl/cache_arrays.sv
hdl/main_memory.sv
hdl/fill_fsm.sv
hdl/cache_top.sv
tb/tb_cache_top.sv

// File: tb/tb_cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_top;

  // Table op codes
  localparam logic op_rd = 1'b0;
  localparam logic op_wr = 1'b1;

  // Expected stall in the first cycle of an access
  localparam logic [1:0] chk_none = 2'd0;
  localparam logic [1:0] chk_hit = 2'd1;
  localparam logic [1:0] chk_miss = 2'd2;

  localparam int stall_limit = 64;
  localparam int reset_cycles = 8;
  localparam int random_count = 40;

  logic                         clk;
  logic                         reset;
  logic                         rd;
  logic                         wr;
  cache_pkg::cache_addr_t       addr;
  logic [cache_pkg::data_w-1:0] wdata;
  logic [cache_pkg::data_w-1:0] rdata;
  logic                         stall;

  // Stimulus table, one entry per access
  logic                         op_q [$];
  logic [cache_pkg::addr_w-1:0] addr_q [$];
  logic [cache_pkg::data_w-1:0] data_q [$];
  logic [1:0]                   chk_q [$];

  // Reference memory of every word written so far
  logic [cache_pkg::data_w-1:0] ref_mem [cache_pkg::mem_words];
  bit                           ref_written [cache_pkg::mem_words];

  // Conflicting sets for the random tail
  logic [cache_pkg::tag_w-1:0]   tag_list [4] = '{6'd1, 6'd2, 6'd5, 6'd7};
  logic [cache_pkg::index_w-1:0] index_list [3] = '{6'd3, 6'd5, 6'd9};

  int seed;

  cache_top uut (
    .clk   (clk),
    .reset (reset),
    .rd    (rd),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .stall (stall)
  );

  // 20 ns period
  always #10 clk = ~clk;

  function automatic logic [15:0] block_addr(input logic [5:0] tag,
                                             input logic [5:0] index,
                                             input logic [3:0] offset);
    return {tag, index, offset};
  endfunction

  function automatic void add_entry(input logic op, input logic [15:0] a,
                                    input logic [15:0] d, input logic [1:0] chk);
    op_q.push_back(op);
    addr_q.push_back(a);
    data_q.push_back(d);
    chk_q.push_back(chk);
  endfunction

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Polls at the falling edge, where stall has settled
  task automatic wait_stall_low(input int entry);
    int cycles;
    cycles = 0;
    while (stall !== 1'b0) begin
      if (cycles >= stall_limit) begin
        $display("Timeout: stall never fell within %0d cycles on entry %0d",
                 stall_limit, entry);
        $display("FAIL: see errors above");
        $fatal(1, "Stall timeout");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  function automatic void build_table();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [31:0] val;
    logic [1:0]  sel;
    logic [5:0]  tag;
    logic [5:0]  index;
    logic [3:0]  offset;
    logic        op;
    a = block_addr(6'd1, 6'd3, 4'd4);
    b = block_addr(6'd5, 6'd3, 4'd6);
    c = block_addr(6'd2, 6'd5, 4'd0);
    // Write into an empty set, then read back
    add_entry(op_wr, a, 16'hA5A5, chk_miss);
    add_entry(op_rd, a, 16'h0000, chk_hit);
    // Byte bit 0 selects the same word
    add_entry(op_rd, a | 16'h0001, 16'h0000, chk_hit);
    // Several offsets of one block
    add_entry(op_wr, c, 16'h1000, chk_miss);
    add_entry(op_wr, c | 16'h0002, 16'h1111, chk_hit);
    add_entry(op_wr, c | 16'h0006, 16'h2222, chk_hit);
    add_entry(op_wr, c | 16'h000A, 16'h3333, chk_hit);
    add_entry(op_wr, c | 16'h000E, 16'h4444, chk_hit);
    add_entry(op_rd, c, 16'h0000, chk_hit);
    add_entry(op_rd, c | 16'h0002, 16'h0000, chk_hit);
    add_entry(op_rd, c | 16'h0006, 16'h0000, chk_hit);
    add_entry(op_rd, c | 16'h000A, 16'h0000, chk_hit);
    add_entry(op_rd, c | 16'h000E, 16'h0000, chk_hit);
    // Same set, two tags, evicting each other
    add_entry(op_wr, b, 16'hBEEF, chk_miss);
    add_entry(op_rd, a, 16'h0000, chk_miss);
    add_entry(op_rd, b, 16'h0000, chk_miss);
    add_entry(op_wr, a, 16'h5A5A, chk_miss);
    add_entry(op_rd, b, 16'h0000, chk_miss);
    add_entry(op_rd, a, 16'h0000, chk_miss);
    // Random tail over three sets and four tags
    for (int n = 0; n < random_count; n++) begin
      val = $random(seed);
      op = val[0];
      val = $random(seed);
      tag = tag_list[val[1:0]];
      val = $random(seed);
      sel = 2'(val % 3);
      index = index_list[sel];
      val = $random(seed);
      offset = val[3:0];
      val = $random(seed);
      add_entry(op, block_addr(tag, index, offset), val[15:0], chk_none);
    end
  endfunction

  initial begin
    logic [14:0] word;
    seed = 97839;
    clk = 1'b0;
    reset = 1'b1;
    rd = 1'b0;
    wr = 1'b0;
    addr = '0;
    wdata = '0;
    build_table();

    for (int c = 0; c < reset_cycles; c++) begin
      @(posedge clk);
    end
    reset <= 1'b0;

    for (int i = 0; i < op_q.size(); i++) begin
      // Inputs held until stall falls
      @(posedge clk);
      rd <= (op_q[i] == op_rd);
      wr <= (op_q[i] == op_wr);
      addr <= addr_q[i];
      wdata <= data_q[i];
      @(negedge clk);
      if (chk_q[i] == chk_hit) begin
        check_value("stall in first cycle of a hit", 16'(stall), 16'd0);
      end else if (chk_q[i] == chk_miss) begin
        check_value("stall in first cycle of a miss", 16'(stall), 16'd1);
      end
      wait_stall_low(i);
      word = addr_q[i][15:1];
      // Write lands at the next edge, model updated now
      if (op_q[i] == op_wr) begin
        ref_mem[word] = data_q[i];
        ref_written[word] = 1'b1;
      end else if (ref_written[word]) begin
        check_value("read data", rdata, ref_mem[word]);
      end
    end

    @(posedge clk);
    rd <= 1'b0;
    wr <= 1'b0;
    @(posedge clk);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
